//--- include/execSlice_params.svh
`ifndef EXEC_SLICE_PARAMS_SVH
`define EXEC_SLICE_PARAMS_SVH

// data path width
`define EXEC_DATA_W 32

// register number width, 32 GPRs
`define EXEC_REG_W 5

// byte distance to the next instruction
`define EXEC_INST_STEP 4

// general exception handler entry, BEV=1
`define EXEC_EXC_VECTOR 32'hbfc00380

`endif

//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

    // integer alu operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  // traps on overflow
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,  // traps on overflow
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLT  = 4'd7,
        ALU_SLTU = 4'd8
    } aluOpE;

    // branch kind, BR_NONE marks a plain alu op
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ, BR_JR
    } brCondE;

endpackage

`default_nettype wire

//--- hw/excPkg.sv
`default_nettype none

package excPkg;

    // mips cause register ExcCode values
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,  // address error on fetch
        EXC_OV   = 5'd12  // arithmetic overflow
    } excCodeE;

endpackage

`default_nettype wire

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "execSlice_params.svh"

module aluUnit (
    input  wire                    clk,
    input  wire                    rstN_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    input  isaPkg::aluOpE          aluOp_i,
    input  logic [`EXEC_DATA_W-1:0] opA_i,
    input  logic [`EXEC_DATA_W-1:0] opB_i,
    input  logic                   regWrite_i,
    input  logic [`EXEC_REG_W-1:0]  destReg_i,
    output logic                   aluValid_o,
    output logic [`EXEC_DATA_W-1:0] aluResult_o,
    output logic                   overflow_o,
    output logic                   regWrite_o,
    output logic [`EXEC_REG_W-1:0]  destReg_o
);

    localparam int MSB = `EXEC_DATA_W - 1;

    logic [MSB:0] sum;
    logic [MSB:0] diff;
    logic [MSB:0] result;
    logic         sumOv;
    logic         diffOv;
    logic         ovNext;
    logic         capture;

    assign sum  = opA_i + opB_i;
    assign diff = opA_i - opB_i;

    // same-sign operands giving a result of the other sign
    assign sumOv  = (opA_i[MSB] == opB_i[MSB]) && (sum[MSB] != opA_i[MSB]);
    assign diffOv = (opA_i[MSB] != opB_i[MSB]) && (diff[MSB] != opA_i[MSB]);

    always_comb begin
        result = '0;
        ovNext = 1'b0;
        case (aluOp_i)
            isaPkg::ALU_ADD: begin
                result = sum;
                ovNext = sumOv;
            end
            isaPkg::ALU_SUB: begin
                result = diff;
                ovNext = diffOv;
            end
            isaPkg::ALU_ADDU: result = sum;
            isaPkg::ALU_SUBU: result = diff;
            isaPkg::ALU_AND:  result = opA_i & opB_i;
            isaPkg::ALU_OR:   result = opA_i | opB_i;
            isaPkg::ALU_XOR:  result = opA_i ^ opB_i;
            isaPkg::ALU_SLT:  result = {{MSB{1'b0}}, $signed(opA_i) < $signed(opB_i)};
            isaPkg::ALU_SLTU: result = {{MSB{1'b0}}, opA_i < opB_i};
            default:          result = '0;
        endcase
    end

    assign capture = valid_i & ~flush_i;  // younger op squashed on flush

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            aluValid_o <= 1'b0;
            overflow_o <= 1'b0;
            regWrite_o <= 1'b0;
        end else begin
            aluValid_o <= capture;
            overflow_o <= capture & ovNext;
            regWrite_o <= capture & regWrite_i;
        end
    end

    always_ff @(posedge clk) begin
        aluResult_o <= result;
        destReg_o   <= destReg_i;
    end

    // opcode must be known whenever an instruction is presented
    aluOpKnown: assert property (@(posedge clk) disable iff (!rstN_i)
        valid_i |-> !$isunknown(aluOp_i));

endmodule

`default_nettype wire

//--- hw/branchCheck.sv
`timescale 1ns/1ps
`default_nettype none

`include "execSlice_params.svh"

module branchCheck (
    input  wire                    clk,
    input  wire                    rstN_i,
    input  logic                   flush_i,
    input  logic                   valid_i,
    input  isaPkg::brCondE         brCond_i,
    input  logic [`EXEC_DATA_W-1:0] opA_i,
    input  logic [`EXEC_DATA_W-1:0] opB_i,
    input  logic [15:0]            imm_i,
    input  logic [`EXEC_DATA_W-1:0] pc_i,
    input  logic                   predTaken_i,
    output logic                   brValid_o,
    output logic                   mispredict_o,
    output logic [`EXEC_DATA_W-1:0] target_o,
    output logic                   addrError_o,
    output logic [`EXEC_DATA_W-1:0] pc_o
);

    logic [`EXEC_DATA_W-1:0] fallThru;
    logic [`EXEC_DATA_W-1:0] brTarget;
    logic [`EXEC_DATA_W-1:0] nextTarget;
    logic                    taken;
    logic                    isJr;
    logic                    capture;

    assign isJr     = (brCond_i == isaPkg::BR_JR);
    assign fallThru = pc_i + `EXEC_INST_STEP;
    assign brTarget = fallThru + {{(`EXEC_DATA_W-18){imm_i[15]}}, imm_i, 2'b00};

    always_comb begin
        case (brCond_i)
            isaPkg::BR_EQ:  taken = (opA_i == opB_i);
            isaPkg::BR_NE:  taken = (opA_i != opB_i);
            isaPkg::BR_LEZ: taken = ($signed(opA_i) <= 0);
            isaPkg::BR_GTZ: taken = ($signed(opA_i) > 0);
            isaPkg::BR_LTZ: taken = opA_i[`EXEC_DATA_W-1];
            isaPkg::BR_GEZ: taken = ~opA_i[`EXEC_DATA_W-1];
            isaPkg::BR_JR:  taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    // jr goes to rs, otherwise where the branch actually lands
    assign nextTarget = isJr ? opA_i : (taken ? brTarget : fallThru);

    assign capture = valid_i & ~flush_i & (brCond_i != isaPkg::BR_NONE);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            brValid_o    <= 1'b0;
            mispredict_o <= 1'b0;
            addrError_o  <= 1'b0;
        end else begin
            brValid_o    <= capture;
            mispredict_o <= capture & (isJr | (taken != predTaken_i));
            addrError_o  <= capture & isJr & (opA_i[1:0] != 2'b00);  // misaligned jr
        end
    end

    always_ff @(posedge clk) begin
        target_o <= nextTarget;
        pc_o     <= pc_i;  // every op, commit needs it for epc
    end

    addrErrOnBranch: assert property (@(posedge clk) disable iff (!rstN_i)
        addrError_o |-> brValid_o);

endmodule

`default_nettype wire

//--- hw/execCommit.sv
`timescale 1ns/1ps
`default_nettype none

`include "execSlice_params.svh"

module execCommit (
    input  wire                    clk,
    input  wire                    rstN_i,
    input  logic                   aluValid_i,
    input  logic [`EXEC_DATA_W-1:0] aluResult_i,
    input  logic                   overflow_i,
    input  logic                   regWrite_i,
    input  logic [`EXEC_REG_W-1:0]  destReg_i,
    input  logic                   brValid_i,
    input  logic                   mispredict_i,
    input  logic [`EXEC_DATA_W-1:0] target_i,
    input  logic                   addrError_i,
    input  logic [`EXEC_DATA_W-1:0] pc_i,
    output logic                   flush_o,
    output logic                   wbValid_o,
    output logic [`EXEC_REG_W-1:0]  wbReg_o,
    output logic [`EXEC_DATA_W-1:0] wbData_o,
    output logic                   redirect_o,
    output logic [`EXEC_DATA_W-1:0] redirectPc_o,
    output logic                   excValid_o,
    output excPkg::excCodeE        excCode_o,
    output logic [`EXEC_DATA_W-1:0] epc_o
);

    logic                    isAlu;
    logic                    ovExc;
    logic                    adelExc;
    logic                    excNow;
    logic                    redirNow;
    logic                    wbNow;
    excPkg::excCodeE         codeNext;
    logic [`EXEC_DATA_W-1:0] redirPcNext;

    // alu unit sees every op, branches are filtered here
    assign isAlu   = aluValid_i & ~brValid_i;
    assign ovExc   = isAlu & overflow_i;
    assign adelExc = brValid_i & addrError_i;
    assign excNow  = ovExc | adelExc;

    assign redirNow = excNow | (brValid_i & mispredict_i);
    assign wbNow    = isAlu & regWrite_i & ~overflow_i;  // overflow kills write-back

    always_comb begin
        if (ovExc) begin
            codeNext = excPkg::EXC_OV;
        end else if (adelExc) begin
            codeNext = excPkg::EXC_ADEL;
        end else begin
            codeNext = excPkg::EXC_NONE;
        end
    end

    assign redirPcNext = excNow ? `EXEC_EXC_VECTOR : target_i;

    assign flush_o = redirNow;  // drop the op entering execute

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            wbValid_o  <= 1'b0;
            redirect_o <= 1'b0;
            excValid_o <= 1'b0;
            excCode_o  <= excPkg::EXC_NONE;
        end else begin
            wbValid_o  <= wbNow;
            redirect_o <= redirNow;
            excValid_o <= excNow;
            excCode_o  <= codeNext;
        end
    end

    always_ff @(posedge clk) begin
        wbReg_o      <= destReg_i;
        wbData_o     <= aluResult_i;
        redirectPc_o <= redirPcNext;
        epc_o        <= pc_i;  // faulting op's own pc, no delay slots
    end

    // a precise exception always steers fetch and never retires a result
    excRedirects: assert property (@(posedge clk) disable iff (!rstN_i)
        excValid_o |-> redirect_o);
    excNoWb: assert property (@(posedge clk) disable iff (!rstN_i)
        excValid_o |-> !wbValid_o);

endmodule

`default_nettype wire

//--- hw/execSlice.sv
`timescale 1ns/1ps
`default_nettype none

`include "execSlice_params.svh"

module execSlice (
    input  wire                    clk,
    input  wire                    rstN_i,
    input  logic                   validI_i,
    input  isaPkg::aluOpE          aluOp_i,
    input  isaPkg::brCondE         brCond_i,
    input  logic [`EXEC_DATA_W-1:0] opA_i,    // rs value
    input  logic [`EXEC_DATA_W-1:0] opB_i,    // rt value
    input  logic [15:0]            imm_i,
    input  logic [`EXEC_DATA_W-1:0] pc_i,
    input  logic                   predTaken_i,
    input  logic                   regWrite_i,
    input  logic [`EXEC_REG_W-1:0]  destReg_i,
    output logic                   wbValid_o,
    output logic [`EXEC_REG_W-1:0]  wbReg_o,
    output logic [`EXEC_DATA_W-1:0] wbData_o,
    output logic                   redirect_o,
    output logic [`EXEC_DATA_W-1:0] redirectPc_o,
    output logic                   excValid_o,
    output excPkg::excCodeE        excCode_o,
    output logic [`EXEC_DATA_W-1:0] epc_o
);

    logic                    flush;
    logic                    aluValid;
    logic [`EXEC_DATA_W-1:0] aluResult;
    logic                    overflow;
    logic                    regWriteE;
    logic [`EXEC_REG_W-1:0]  destRegE;
    logic                    brValid;
    logic                    mispredict;
    logic [`EXEC_DATA_W-1:0] target;
    logic                    addrError;
    logic [`EXEC_DATA_W-1:0] pcE;

    aluUnit aluU (
        .clk(clk), .rstN_i(rstN_i), .flush_i(flush), .valid_i(validI_i),
        .aluOp_i(aluOp_i), .opA_i(opA_i), .opB_i(opB_i),
        .regWrite_i(regWrite_i), .destReg_i(destReg_i),
        .aluValid_o(aluValid), .aluResult_o(aluResult), .overflow_o(overflow),
        .regWrite_o(regWriteE), .destReg_o(destRegE)
    );

    // branch resolution runs beside the alu
    branchCheck brU (
        .clk(clk), .rstN_i(rstN_i), .flush_i(flush), .valid_i(validI_i),
        .brCond_i(brCond_i), .opA_i(opA_i), .opB_i(opB_i), .imm_i(imm_i),
        .pc_i(pc_i), .predTaken_i(predTaken_i),
        .brValid_o(brValid), .mispredict_o(mispredict), .target_o(target),
        .addrError_o(addrError), .pc_o(pcE)
    );

    execCommit cmtU (
        .clk(clk), .rstN_i(rstN_i),
        .aluValid_i(aluValid), .aluResult_i(aluResult), .overflow_i(overflow),
        .regWrite_i(regWriteE), .destReg_i(destRegE),
        .brValid_i(brValid), .mispredict_i(mispredict), .target_i(target),
        .addrError_i(addrError), .pc_i(pcE),
        .flush_o(flush),
        .wbValid_o(wbValid_o), .wbReg_o(wbReg_o), .wbData_o(wbData_o),
        .redirect_o(redirect_o), .redirectPc_o(redirectPc_o),
        .excValid_o(excValid_o), .excCode_o(excCode_o), .epc_o(epc_o)
    );

endmodule

`default_nettype wire

//--- verification/execSliceTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "execSlice_params.svh"

module execSliceTb;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ROWS   = 64;

    // one instruction slot as presented to the DUT
    typedef struct packed {
        logic                    valid;
        isaPkg::aluOpE           op;
        isaPkg::brCondE          cond;
        logic [`EXEC_DATA_W-1:0] a;
        logic [`EXEC_DATA_W-1:0] b;
        logic [15:0]             imm;
        logic [`EXEC_DATA_W-1:0] pc;
        logic                    pred;
        logic                    regWr;
        logic [`EXEC_REG_W-1:0]  dest;
    } rowT;

    typedef struct packed {
        logic                    wb;
        logic [`EXEC_REG_W-1:0]  wbReg;
        logic [`EXEC_DATA_W-1:0] wbData;
        logic                    redir;
        logic [`EXEC_DATA_W-1:0] redirPc;
        logic                    exc;
        excPkg::excCodeE         code;
        logic [`EXEC_DATA_W-1:0] epc;
    } expT;

    logic                    clk;
    logic                    rstN;
    logic                    validI;
    isaPkg::aluOpE           aluOp;
    isaPkg::brCondE          brCond;
    logic [`EXEC_DATA_W-1:0] opA;
    logic [`EXEC_DATA_W-1:0] opB;
    logic [15:0]             imm;
    logic [`EXEC_DATA_W-1:0] pc;
    logic                    predTaken;
    logic                    regWrite;
    logic [`EXEC_REG_W-1:0]  destReg;
    logic                    wbValid;
    logic [`EXEC_REG_W-1:0]  wbReg;
    logic [`EXEC_DATA_W-1:0] wbData;
    logic                    redirect;
    logic [`EXEC_DATA_W-1:0] redirectPc;
    logic                    excValid;
    excPkg::excCodeE         excCode;
    logic [`EXEC_DATA_W-1:0] epc;

    rowT                     rows [MAX_ROWS];
    expT                     expRows [MAX_ROWS];
    string                   rowName [MAX_ROWS];
    int                      rowCnt;
    logic [`EXEC_DATA_W-1:0] nextPc;
    logic [31:0]             rngState;
    int                      wbErrs;
    int                      redirErrs;
    int                      excErrs;
    bit                      tableReady = 1'b0;

    execSlice dut_i (
        .clk(clk), .rstN_i(rstN), .validI_i(validI), .aluOp_i(aluOp),
        .brCond_i(brCond), .opA_i(opA), .opB_i(opB), .imm_i(imm), .pc_i(pc),
        .predTaken_i(predTaken), .regWrite_i(regWrite), .destReg_i(destReg),
        .wbValid_o(wbValid), .wbReg_o(wbReg), .wbData_o(wbData),
        .redirect_o(redirect), .redirectPc_o(redirectPc),
        .excValid_o(excValid), .excCode_o(excCode), .epc_o(epc)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
        return rngState;
    endfunction

    function automatic logic [`EXEC_DATA_W-1:0] refAlu(input isaPkg::aluOpE op,
            input logic [`EXEC_DATA_W-1:0] a, input logic [`EXEC_DATA_W-1:0] b);
        case (op)
            isaPkg::ALU_ADD, isaPkg::ALU_ADDU: return a + b;
            isaPkg::ALU_SUB, isaPkg::ALU_SUBU: return a - b;
            isaPkg::ALU_AND:  return a & b;
            isaPkg::ALU_OR:   return a | b;
            isaPkg::ALU_XOR:  return a ^ b;
            isaPkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            isaPkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:          return '0;
        endcase
    endfunction

    // one extra sign bit, overflow when the top two bits disagree
    function automatic logic refOverflow(input isaPkg::aluOpE op,
            input logic [`EXEC_DATA_W-1:0] a, input logic [`EXEC_DATA_W-1:0] b);
        logic [`EXEC_DATA_W:0] wide;
        if (op == isaPkg::ALU_ADD) begin
            wide = {a[`EXEC_DATA_W-1], a} + {b[`EXEC_DATA_W-1], b};
        end else if (op == isaPkg::ALU_SUB) begin
            wide = {a[`EXEC_DATA_W-1], a} - {b[`EXEC_DATA_W-1], b};
        end else begin
            wide = '0;
        end
        return wide[`EXEC_DATA_W] ^ wide[`EXEC_DATA_W-1];
    endfunction

    function automatic logic refTaken(input isaPkg::brCondE cond,
            input logic [`EXEC_DATA_W-1:0] a, input logic [`EXEC_DATA_W-1:0] b);
        case (cond)
            isaPkg::BR_EQ:  return a == b;
            isaPkg::BR_NE:  return a != b;
            isaPkg::BR_LEZ: return $signed(a) <= 0;
            isaPkg::BR_GTZ: return $signed(a) > 0;
            isaPkg::BR_LTZ: return $signed(a) < 0;
            isaPkg::BR_GEZ: return $signed(a) >= 0;
            isaPkg::BR_JR:  return 1'b1;
            default:        return 1'b0;
        endcase
    endfunction

    task automatic addRow(input string name, input logic valid, input isaPkg::aluOpE op,
            input isaPkg::brCondE cond, input logic [`EXEC_DATA_W-1:0] a,
            input logic [`EXEC_DATA_W-1:0] b, input logic [15:0] offs, input logic pred,
            input logic regWr, input logic [`EXEC_REG_W-1:0] dest);
        rows[rowCnt] = '{valid, op, cond, a, b, offs, nextPc, pred, regWr, dest};
        rowName[rowCnt] = name;
        nextPc = nextPc + `EXEC_INST_STEP;
        rowCnt++;
    endtask

    task automatic addAlu(input string name, input isaPkg::aluOpE op,
            input logic [`EXEC_DATA_W-1:0] a, input logic [`EXEC_DATA_W-1:0] b,
            input logic regWr, input logic [`EXEC_REG_W-1:0] dest);
        addRow(name, 1'b1, op, isaPkg::BR_NONE, a, b, 16'h0, 1'b0, regWr, dest);
    endtask

    task automatic addFiller(input string name);
        addAlu(name, isaPkg::ALU_XOR, nextRand(), nextRand(), 1'b1, 5'd31);
    endtask

    task automatic addIdle(input string name);
        addRow(name, 1'b0, isaPkg::ALU_ADD, isaPkg::BR_NONE, '0, '0, 16'h0, 1'b0, 1'b0, '0);
    endtask

    // wrong flips the prediction away from the real outcome
    task automatic addBranch(input string name, input isaPkg::brCondE cond,
            input logic [`EXEC_DATA_W-1:0] a, input logic [`EXEC_DATA_W-1:0] b,
            input logic [15:0] offs, input logic wrong);
        addRow(name, 1'b1, isaPkg::ALU_ADDU, cond, a, b, offs,
            refTaken(cond, a, b) ^ wrong, 1'b0, '0);
    endtask

    task automatic buildTable();
        isaPkg::aluOpE           op;
        isaPkg::brCondE          cond;
        logic [`EXEC_DATA_W-1:0] a;
        logic [`EXEC_DATA_W-1:0] b;
        logic [15:0]             offs;
        logic [`EXEC_REG_W-1:0]  regNo;
        isaPkg::brCondE          condList [6] = '{isaPkg::BR_EQ, isaPkg::BR_NE,
            isaPkg::BR_LEZ, isaPkg::BR_GTZ, isaPkg::BR_LTZ, isaPkg::BR_GEZ};
        logic [`EXEC_DATA_W-1:0] aList [6] = '{32'd5, 32'd5, 32'd0, 32'hfffffffd,
            32'hfffffffd, 32'd16};
        regNo = 5'd1;
        addIdle("idle_start0");
        addIdle("idle_start1");
        for (int i = 0; i < 9; i++) begin
            op = isaPkg::aluOpE'(i);
            a = nextRand();
            b = nextRand();
            if (op == isaPkg::ALU_ADD || op == isaPkg::ALU_SUB) begin
                a = a >> 2;  // keep clear of overflow
                b = b >> 2;
            end
            addAlu({"rand_", op.name()}, op, a, b, 1'b1, regNo);
            regNo = regNo + 5'd1;
        end
        addAlu("or_nowrite", isaPkg::ALU_OR, nextRand(), nextRand(), 1'b0, 5'd9);
        addAlu("add_ov", isaPkg::ALU_ADD, 32'h7fffffff, 32'h1, 1'b1, 5'd10);
        addFiller("add_ov_squash");
        addAlu("addu_wrap", isaPkg::ALU_ADDU, 32'h7fffffff, 32'h1, 1'b1, 5'd10);
        addAlu("sub_ov", isaPkg::ALU_SUB, 32'h80000000, 32'h1, 1'b1, 5'd11);
        addFiller("sub_ov_squash");
        addAlu("subu_wrap", isaPkg::ALU_SUBU, 32'h80000000, 32'h1, 1'b1, 5'd11);
        for (int i = 0; i < 6; i++) begin
            cond = condList[i];
            offs = i[0] ? 16'hfff8 : 16'h0010;  // backward and forward offsets
            addBranch({cond.name(), "_ok"}, cond, aList[i], 32'd5, offs, 1'b0);
            addBranch({cond.name(), "_miss"}, cond, aList[i], 32'd5, offs, 1'b1);
            addFiller({cond.name(), "_squash"});
            addFiller({cond.name(), "_after"});
        end
        addBranch("jr_aligned", isaPkg::BR_JR, 32'h00400100, '0, 16'h0, 1'b0);
        addFiller("jr_squash");
        addBranch("jr_misaligned", isaPkg::BR_JR, 32'h00400102, '0, 16'h0, 1'b0);
        addFiller("adel_squash");
        addIdle("idle_end0");
        addIdle("idle_end1");
    endtask

    task automatic buildExpected();
        rowT                     r;
        expT                     e;
        logic                    flushPrev;
        logic                    live;
        logic                    isBr;
        logic                    ov;
        logic                    adel;
        logic                    taken;
        logic [`EXEC_DATA_W-1:0] brOffset;
        logic [`EXEC_DATA_W-1:0] target;
        flushPrev = 1'b0;
        for (int i = 0; i < rowCnt; i++) begin
            r = rows[i];
            e = '0;
            live = r.valid & ~flushPrev;  // dropped behind a redirect
            isBr = (r.cond != isaPkg::BR_NONE);
            ov = ~isBr & refOverflow(r.op, r.a, r.b);
            adel = (r.cond == isaPkg::BR_JR) && (r.a[1:0] != 2'b00);
            taken = refTaken(r.cond, r.a, r.b);
            if (r.cond == isaPkg::BR_JR) begin
                target = r.a;
            end else if (taken) begin
                brOffset = $signed(r.imm) * 4;  // word offset in bytes
                target = r.pc + `EXEC_INST_STEP + brOffset;
            end else begin
                target = r.pc + `EXEC_INST_STEP;
            end
            e.exc = live & (ov | adel);
            if (live && ov) begin
                e.code = excPkg::EXC_OV;
            end else if (live && adel) begin
                e.code = excPkg::EXC_ADEL;
            end else begin
                e.code = excPkg::EXC_NONE;
            end
            e.epc = r.pc;
            e.redir = e.exc | (live & isBr & ((r.cond == isaPkg::BR_JR) | (taken != r.pred)));
            e.redirPc = e.exc ? `EXEC_EXC_VECTOR : target;
            e.wb = live & ~isBr & r.regWr & ~ov;
            e.wbReg = r.dest;
            e.wbData = refAlu(r.op, r.a, r.b);
            expRows[i] = e;
            flushPrev = e.redir;
        end
    endtask

    task automatic driveRow(input rowT r);
        validI    <= r.valid;
        aluOp     <= r.op;
        brCond    <= r.cond;
        opA       <= r.a;
        opB       <= r.b;
        imm       <= r.imm;
        pc        <= r.pc;
        predTaken <= r.pred;
        regWrite  <= r.regWr;
        destReg   <= r.dest;
    endtask

    task automatic checkWb(input string name, input logic expV, input logic actV,
            input logic [`EXEC_REG_W-1:0] expReg, input logic [`EXEC_REG_W-1:0] actReg,
            input logic [`EXEC_DATA_W-1:0] expData, input logic [`EXEC_DATA_W-1:0] actData);
        if (actV !== expV) begin
            $display("ERR %s wbValid expected %0b actual %0b", name, expV, actV);
            wbErrs++;
        end else if (expV && actReg !== expReg) begin
            $display("ERR %s wbReg expected %0d actual %0d", name, expReg, actReg);
            wbErrs++;
        end else if (expV && actData !== expData) begin
            $display("ERR %s wbData expected %h actual %h", name, expData, actData);
            wbErrs++;
        end
    endtask

    task automatic checkRedirect(input string name, input logic expV, input logic actV,
            input logic [`EXEC_DATA_W-1:0] expPc, input logic [`EXEC_DATA_W-1:0] actPc);
        if (actV !== expV) begin
            $display("ERR %s redirect expected %0b actual %0b", name, expV, actV);
            redirErrs++;
        end else if (expV && actPc !== expPc) begin
            $display("ERR %s redirectPc expected %h actual %h", name, expPc, actPc);
            redirErrs++;
        end
    endtask

    task automatic checkExc(input string name, input logic expV, input logic actV,
            input excPkg::excCodeE expCode, input excPkg::excCodeE actCode,
            input logic [`EXEC_DATA_W-1:0] expEpc, input logic [`EXEC_DATA_W-1:0] actEpc);
        if (actV !== expV) begin
            $display("ERR %s excValid expected %0b actual %0b", name, expV, actV);
            excErrs++;
        end else if (actCode !== expCode) begin
            $display("ERR %s excCode expected %s actual %s", name, expCode.name(),
                actCode.name());
            excErrs++;
        end else if (expV && actEpc !== expEpc) begin
            $display("ERR %s epc expected %h actual %h", name, expEpc, actEpc);
            excErrs++;
        end
    endtask

    task automatic checkRow(input int k);
        checkWb(rowName[k], expRows[k].wb, wbValid, expRows[k].wbReg, wbReg,
            expRows[k].wbData, wbData);
        checkRedirect(rowName[k], expRows[k].redir, redirect, expRows[k].redirPc, redirectPc);
        checkExc(rowName[k], expRows[k].exc, excValid, expRows[k].code, excCode,
            expRows[k].epc, epc);
    endtask

    initial begin
        rstN      = 1'b0;
        validI    = 1'b0;
        aluOp     = isaPkg::ALU_ADD;
        brCond    = isaPkg::BR_NONE;
        opA       = '0;
        opB       = '0;
        imm       = '0;
        pc        = '0;
        predTaken = 1'b0;
        regWrite  = 1'b0;
        destReg   = '0;
        rngState  = 32'h701c;
        nextPc    = 32'h00400000;
        rowCnt    = 0;
        wbErrs    = 0;
        redirErrs = 0;
        excErrs   = 0;
        buildTable();
        buildExpected();
        tableReady = 1'b1;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        // results of row i show up two edges after it is driven
        for (int i = 0; i < rowCnt + 2; i++) begin
            @(posedge clk);
            if (i < rowCnt) begin
                driveRow(rows[i]);
            end else begin
                validI <= 1'b0;
            end
            @(negedge clk);
            if (i >= 2) begin
                checkRow(i - 2);
            end
        end
        $display("errors: wb %0d, redirect %0d, exception %0d", wbErrs, redirErrs, excErrs);
        if (wbErrs + redirErrs + excErrs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (tableReady);
        #((rowCnt + 10) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in the expected time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- execSlice.f
+incdir+include
hw/isaPkg.sv
hw/excPkg.sv
hw/aluUnit.sv
hw/branchCheck.sv
hw/execCommit.sv
hw/execSlice.sv
verification/execSliceTb.sv

//--- run.sh
#!/bin/sh
# compile and run the execSlice testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module execSliceTb -o execSliceSim -f execSlice.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/execSliceSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qF "TEST RESULT: PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
